// File: fib_apb_regs.sv
`timescale 1ns/10ps

module fib_apb_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  fib_pkg::apb_req_t apb_req,
    output fib_pkg::apb_rsp_t apb_rsp,
    output logic              req_valid,
    output fib_pkg::value_t   req_value,
    input  logic              res_valid,
    input  fib_pkg::result_t  res
);

    logic             access;
    logic             hit_value;
    logic             addr_ok;
    logic             accept;
    logic             busy;
    logic             done;
    logic             err;
    fib_pkg::digits_t digits_q;
    fib_pkg::value_t  decoded_q;
    logic [31:0]      rdata;

    assign access    = apb_req.psel & apb_req.penable;
    assign hit_value = (apb_req.paddr == fib_pkg::addr_value);
    assign accept    = access & apb_req.pwrite & hit_value & ~busy;

    always_comb
    begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (apb_req.paddr)
            fib_pkg::addr_value:
                rdata[fib_pkg::value_w-1:0] = req_value;
            fib_pkg::addr_status:
            begin
                rdata[fib_pkg::stat_busy_bit] = busy;
                rdata[fib_pkg::stat_done_bit] = done;
                rdata[fib_pkg::stat_err_bit]  = err;
            end
            fib_pkg::addr_digits:
                rdata[fib_pkg::num_digits-1:0] = digits_q;
            fib_pkg::addr_decoded:
                rdata[fib_pkg::value_w-1:0] = decoded_q;
            default:
                addr_ok = 1'b0;
        endcase
    end

    // zero wait states, error decided in the access phase
    always_comb
    begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
        apb_rsp.pslverr = access & (~addr_ok
                                    | (apb_req.pwrite & ~hit_value)  // read-only
                                    | (apb_req.pwrite & hit_value & busy));
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_valid <= 1'b0;
            req_value <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            err       <= 1'b0;
            digits_q  <= '0;
            decoded_q <= '0;
        end
        else
        begin
            req_valid <= accept; // one-cycle pulse
            if (res_valid)
            begin
                busy      <= 1'b0;
                done      <= 1'b1;
                digits_q  <= res.digits;
                decoded_q <= res.decoded;
                err       <= res.err;
            end
            if (accept)
            begin
                req_value <= apb_req.pwdata[fib_pkg::value_w-1:0];
                busy      <= 1'b1;
                done      <= 1'b0;
            end
        end
    end

endmodule

// File: fib_codec.f
fib_pkg.sv
fib_digit_stage.sv
pipe_reg.sv
fib_encoder.sv
fib_decoder.sv
fib_apb_regs.sv
fib_codec_top.sv
fib_codec_asserts.sv
fib_codec_tb.sv

// File: fib_codec_asserts.sv
`timescale 1ns/10ps

module fib_codec_asserts (
    input logic              clk,
    input logic              rst_n,
    input fib_pkg::apb_req_t apb_req,
    input fib_pkg::apb_rsp_t apb_rsp,
    input logic              req_valid,
    input logic              res_valid
);

    // zero wait states
    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else $error("pready low during an access phase");

    // one value in encoder and decoder at a time
    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !($past(req_valid, 1) || $past(req_valid, 2)
                        || $past(req_valid, 3) || $past(req_valid, 4)))
        else $error("request issued while one is still in flight");

    // encoder 3 + decoder 1
    a_res_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $past(req_valid, 4) |-> res_valid)
        else $error("result missing 4 cycles after request");

    a_res_only_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> $past(req_valid, 4))
        else $error("result without a request 4 cycles earlier");

endmodule

bind fib_codec_top fib_codec_asserts asserts_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .req_valid(req_valid),
    .res_valid(res_valid)
);

// File: fib_codec_tb.sv
`timescale 1ns/10ps

module fib_codec_tb;

    localparam int num_vec  = 20;
    localparam int busy_vec = 12;  // 12345 in the data file
    localparam int poll_max = 50;

    logic              clk;
    logic              rst_n;
    fib_pkg::apb_req_t apb_req;
    fib_pkg::apb_rsp_t apb_rsp;

    logic [31:0] tdata [0:3*num_vec-1]; // value, digits, sum per vector
    int          seed;

    fib_codec_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    always #10 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_digits(input string name, input fib_pkg::digits_t exp,
                                input fib_pkg::digits_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_value(input string name, input fib_pkg::value_t exp,
                               input fib_pkg::value_t act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_now($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
    endtask

    // setup phase, access phase, then idle
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #5;
        rdata  = apb_rsp.prdata; // settled mid access phase
        slverr = apb_rsp.pslverr;
        check_flag("pready in access phase", 1'b1, apb_rsp.pready);
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             output logic slverr);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, wdata, unused, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        apb_transfer(1'b0, addr, 32'h0, rdata, slverr);
    endtask

    task automatic wait_done(input string name, output logic [31:0] stat);
        logic serr;
        int   cycles;
        cycles = 0;
        stat   = '0;
        while (!stat[fib_pkg::stat_done_bit])
        begin
            if (cycles >= poll_max)
                fail_now($sformatf("%s: done bit not set within %0d cycles", name, poll_max));
            else
            begin
                apb_read(fib_pkg::addr_status, stat, serr);
                cycles += 3; // one read spans three edges
            end
        end
    endtask

    task automatic run_value(input string name, input fib_pkg::value_t value,
                             output fib_pkg::digits_t digits, output fib_pkg::value_t decoded);
        logic [31:0] stat;
        logic [31:0] rdata;
        logic        serr;
        apb_write(fib_pkg::addr_value, 32'(value), serr);
        check_flag({name, " write error"}, 1'b0, serr);
        wait_done(name, stat);
        check_flag({name, " busy"}, 1'b0, stat[fib_pkg::stat_busy_bit]);
        check_flag({name, " round trip error"}, 1'b0, stat[fib_pkg::stat_err_bit]);
        apb_read(fib_pkg::addr_digits, rdata, serr);
        digits = rdata[fib_pkg::num_digits-1:0];
        apb_read(fib_pkg::addr_decoded, rdata, serr);
        decoded = rdata[fib_pkg::value_w-1:0];
        check_value({name, " decoded"}, value, decoded);
    endtask

    initial
    begin
        fib_pkg::value_t  value;
        fib_pkg::digits_t digits;
        fib_pkg::value_t  decoded;
        logic [31:0]      rdata;
        logic [31:0]      stat;
        logic [31:0]      rnd;
        logic             serr;
        string            name;

        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        seed    = 8933;
        $readmemh("fib_codec_testdata.txt", tdata);
        if (tdata[3*num_vec-1] !== 32'h7FFFF)
            fail_now("test data file is missing or incomplete");
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // everything reads zero out of reset
        apb_read(fib_pkg::addr_status, rdata, serr);
        check_flag("reset status read error", 1'b0, serr);
        check_value("reset status", '0, rdata[fib_pkg::value_w-1:0]);
        apb_read(fib_pkg::addr_digits, rdata, serr);
        check_digits("reset digits", '0, rdata[fib_pkg::num_digits-1:0]);
        apb_read(fib_pkg::addr_decoded, rdata, serr);
        check_value("reset decoded", '0, rdata[fib_pkg::value_w-1:0]);
        apb_read(fib_pkg::addr_value, rdata, serr);
        check_value("reset value", '0, rdata[fib_pkg::value_w-1:0]);

        for (int i = 0; i < num_vec; i++)
        begin
            name = $sformatf("vector %0d", i);
            run_value(name, tdata[3*i][fib_pkg::value_w-1:0], digits, decoded);
            check_digits({name, " digits"}, tdata[3*i+1][fib_pkg::num_digits-1:0], digits);
            check_value({name, " sum"}, tdata[3*i+2][fib_pkg::value_w-1:0], decoded);
        end

        // second write bounces, first result survives
        apb_write(fib_pkg::addr_value, tdata[3*busy_vec], serr);
        check_flag("first write error", 1'b0, serr);
        apb_write(fib_pkg::addr_value, 32'h00001, serr);
        check_flag("write while busy error", 1'b1, serr);
        wait_done("busy test", stat);
        apb_read(fib_pkg::addr_digits, rdata, serr);
        check_digits("busy test digits", tdata[3*busy_vec+1][fib_pkg::num_digits-1:0],
                     rdata[fib_pkg::num_digits-1:0]);
        apb_read(fib_pkg::addr_decoded, rdata, serr);
        check_value("busy test decoded", tdata[3*busy_vec+2][fib_pkg::value_w-1:0],
                    rdata[fib_pkg::value_w-1:0]);

        apb_read(8'h10, rdata, serr);
        check_flag("unmapped read error", 1'b1, serr);
        apb_write(8'h10, 32'h1, serr);
        check_flag("unmapped write error", 1'b1, serr);
        apb_write(fib_pkg::addr_digits, 32'h1, serr);
        check_flag("digits write error", 1'b1, serr);
        apb_read(fib_pkg::addr_digits, rdata, serr);
        check_digits("digits after bad write", tdata[3*busy_vec+1][fib_pkg::num_digits-1:0],
                     rdata[fib_pkg::num_digits-1:0]);

        for (int i = 0; i < 40; i++)
        begin
            rnd   = $random(seed);
            value = rnd[fib_pkg::value_w-1:0];
            name  = $sformatf("random %0d", i);
            run_value(name, value, digits, decoded);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: fib_codec_testdata.txt
// value  digits  decoded_sum, all hex
// digits bit 26 is Fibonacci digit 27, bit 0 is digit 1
00000 0000000 00000
00001 0000001 00001
00002 0000003 00002
00003 0000006 00003
00004 0000007 00004
00005 000000C 00005
00007 000000F 00007
0000A 000001C 0000A
00059 0000300 00059
00064 000031E 00064
003DB 0006000 003DB
003E8 0006030 003E8
03039 00C78C1 03039
0FFFF 0787C06 0FFFF
30D40 301E01E 30D40
4D972 3FFFFFF 4D972
4D973 4000000 4D973
55555 4319C0F 55555
61A80 4C61861 61A80
7FFFF 707C31C 7FFFF

// File: fib_codec_top.sv
`timescale 1ns/10ps

module fib_codec_top (
    input  logic              clk,
    input  logic              rst_n,
    input  fib_pkg::apb_req_t apb_req,
    output fib_pkg::apb_rsp_t apb_rsp
);

    logic             req_valid;
    fib_pkg::value_t  req_value;
    logic             enc_valid;
    fib_pkg::digits_t enc_digits;
    fib_pkg::value_t  enc_value;  // original value carried with the digits
    logic             res_valid;
    fib_pkg::result_t res;

    fib_apb_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .req_valid(req_valid),
        .req_value(req_value),
        .res_valid(res_valid),
        .res      (res)
    );

    fib_encoder encoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_value  (req_value),
        .out_valid (enc_valid),
        .out_digits(enc_digits),
        .out_value (enc_value)
    );

    fib_decoder decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (enc_valid),
        .in_digits(enc_digits),
        .in_value (enc_value),
        .out_valid(res_valid),
        .out_res  (res)
    );

endmodule

// File: fib_decoder.sv
`timescale 1ns/10ps

module fib_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  fib_pkg::digits_t in_digits,
    input  fib_pkg::value_t  in_value,
    output logic             out_valid,
    output fib_pkg::result_t out_res
);

    logic [31:0]      sum_wide; // wider than value_t, catches overflow
    fib_pkg::result_t res_d;

    always_comb
    begin
        sum_wide = '0;
        for (int i = 1; i <= fib_pkg::num_digits; i++)
        begin
            if (in_digits[i - 1])
                sum_wide = sum_wide + fib_pkg::fib_weight[i];
        end
    end

    always_comb
    begin
        res_d.digits  = in_digits;
        res_d.decoded = fib_pkg::value_t'(sum_wide);
        res_d.err     = (sum_wide != 32'(in_value)); // no round trip
    end

    pipe_reg #(
        .payload_t(fib_pkg::result_t)
    ) out_reg_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (res_d),
        .out_valid(out_valid),
        .out_data (out_res)
    );

endmodule

// File: fib_digit_stage.sv
`timescale 1ns/10ps

module fib_digit_stage #(
    parameter int digit_idx = 1
) (
    input  fib_pkg::stage_t stage_in,
    output fib_pkg::stage_t stage_out
);

    localparam fib_pkg::value_t weight = fib_pkg::value_t'(fib_pkg::fib_weight[digit_idx]);

    logic        digit;
    logic [31:0] res_ext;

    assign res_ext = 32'(stage_in.residue);

    generate
        if (digit_idx == fib_pkg::num_digits)
        begin : g_top
            assign digit = (res_ext >= fib_pkg::fib_weight[digit_idx]); // nothing above
        end
        else if (digit_idx == 1)
        begin : g_last
            assign digit = stage_in.residue[0];
        end
        else
        begin : g_mid
            localparam logic [31:0] upper = fib_pkg::fib_weight[digit_idx]
                                          + fib_pkg::fib_weight[digit_idx - 1];

            always_comb
            begin
                if (res_ext >= upper)
                    digit = 1'b1;
                else if (res_ext < fib_pkg::fib_weight[digit_idx])
                    digit = 1'b0;
                else
                    digit = stage_in.prev; // ambiguous band, follow stage above
            end
        end
    endgenerate

    always_comb
    begin
        stage_out                      = stage_in;
        stage_out.digits[digit_idx - 1] = digit;
        stage_out.residue              = stage_in.residue - (digit ? weight : '0);
        stage_out.prev                 = digit;
    end

endmodule

// File: fib_encoder.sv
`timescale 1ns/10ps

module fib_encoder (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  fib_pkg::value_t  in_value,
    output logic             out_valid,
    output fib_pkg::digits_t out_digits,
    output fib_pkg::value_t  out_value
);

    fib_pkg::stage_t stg_in  [fib_pkg::num_digits];
    fib_pkg::stage_t stg_out [fib_pkg::num_digits];
    fib_pkg::stage_t slice_q [fib_pkg::num_slices];
    fib_pkg::value_t value_q [fib_pkg::num_slices]; // original value, one per slice

    logic [fib_pkg::num_slices:0] vld;

    assign vld[0] = in_valid;

    generate
        for (genvar k = 0; k < fib_pkg::num_digits; k++)
        begin : g_chain
            if (k == 0)
            begin : g_head
                assign stg_in[k] = fib_pkg::stage_t'{residue: in_value, digits: '0, prev: 1'b0};
            end
            else if (k % fib_pkg::stages_per_slice == 0)
            begin : g_from_slice
                assign stg_in[k] = slice_q[k / fib_pkg::stages_per_slice - 1];
            end
            else
            begin : g_direct
                assign stg_in[k] = stg_out[k - 1];
            end

            fib_digit_stage #(
                .digit_idx(fib_pkg::num_digits - k)
            ) stage_i (
                .stage_in (stg_in[k]),
                .stage_out(stg_out[k])
            );

            if ((k + 1) % fib_pkg::stages_per_slice == 0)
            begin : g_slice
                pipe_reg #(
                    .payload_t(fib_pkg::stage_t)
                ) slice_i (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .in_valid (vld[k / fib_pkg::stages_per_slice]),
                    .in_data  (stg_out[k]),
                    .out_valid(vld[k / fib_pkg::stages_per_slice + 1]),
                    .out_data (slice_q[k / fib_pkg::stages_per_slice])
                );
            end
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        value_q[0] <= in_value;
        for (int s = 1; s < fib_pkg::num_slices; s++)
        begin
            value_q[s] <= value_q[s - 1];
        end
    end

    assign out_valid  = vld[fib_pkg::num_slices];
    assign out_digits = slice_q[fib_pkg::num_slices - 1].digits;
    assign out_value  = value_q[fib_pkg::num_slices - 1];

endmodule

// File: fib_pkg.sv
package fib_pkg;

    localparam int value_w          = 19;
    localparam int num_digits       = 27;
    localparam int stages_per_slice = 9;
    localparam int num_slices       = num_digits / stages_per_slice;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // weight of each digit, digit 27 first
    localparam logic [31:0] fib_weight [num_digits:1] = '{
        32'd317811, 32'd121393, 32'd75025, 32'd46368, 32'd28657,
        32'd17711,  32'd10946,  32'd6765,  32'd4181,  32'd2584,
        32'd1597,   32'd987,    32'd610,   32'd377,   32'd233,
        32'd144,    32'd89,     32'd55,    32'd34,    32'd21,
        32'd13,     32'd8,      32'd5,     32'd3,     32'd2,
        32'd1,      32'd1
    };

    localparam logic [apb_addr_w-1:0] addr_value   = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_status  = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_digits  = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_decoded = 8'h0C;

    localparam int stat_busy_bit = 0;
    localparam int stat_done_bit = 1;
    localparam int stat_err_bit  = 2;

    typedef logic [value_w-1:0]    value_t;
    typedef logic [num_digits-1:0] digits_t; // bit 26 is digit 27

    typedef struct packed {
        value_t  residue;
        digits_t digits;
        logic    prev;    // digit decided one stage up
    } stage_t;

    typedef struct packed {
        digits_t digits;
        value_t  decoded;
        logic    err;
    } result_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_data_w-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // payload only moves with a valid beat
    always_ff @(posedge clk)
    begin
        if (in_valid)
            out_data <= in_data;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module fib_codec_tb -o Vfib_codec_tb -f fib_codec.f

status=0
out=$(./obj_dir/Vfib_codec_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
